// ==== verilog/cdc_cfg_pkg.sv ====
// Sizing and quasi-static configuration constants for the clock domain controller
package cdc_cfg_pkg;

    // Number of async gclock requests
    localparam int AREQ = 2;

    // Holdoff fields are log2 of a cycle count
    localparam int HOLDOFF_W = 4;

    // Idle timer width, largest target is 2^15
    localparam int ITBITS = 16;

    // IOSF ISM state width
    localparam int ISM_W = 3;

endpackage : cdc_cfg_pkg

// ==== verilog/cdc_state_pkg.sv ====
// Main controller and ISM state encodings
package cdc_state_pkg;

    // Main clock domain controller sequence
    typedef enum logic [2:0] {
        ACTIVE      = 3'd0,                     // Clock running, domain busy
        IDLE_HOLD   = 3'd1,                     // Idle, holdoff timer counting
        GATED       = 3'd2,                     // Gate closed, clkreq still high
        OFF_PENDING = 3'd3,                     // clkreq dropping, waiting for clkack low
        LOCKED      = 3'd4,                     // Fully off, power gate allowed
        WAKE_WAIT   = 3'd5                      // clkreq back up, waiting for clkack high
    } cdc_state_t;

    // IOSF ISM, anything but idle counts as activity
    typedef enum logic [cdc_cfg_pkg::ISM_W-1:0] {
        ISM_IDLE        = 3'b000,
        ISM_IDLE_REQ    = 3'b001,
        ISM_ACTIVE_REQ  = 3'b010,
        ISM_ACTIVE      = 3'b011,
        ISM_CREDIT_REQ  = 3'b100,
        ISM_CREDIT_INIT = 3'b101,
        ISM_CREDIT_DONE = 3'b110,
        ISM_IDLE_NAK    = 3'b111
    } ism_state_t;

endpackage : cdc_state_pkg

// ==== verilog/cdc_ctrl_if.sv ====
`timescale 1ns/1ps

// Control bundle between the main controller and the power gate side
interface cdc_ctrl_if;

    logic domain_locked;                        // Domain locked, clkreq may drop
    logic ism_wake;                             // Activity seen while gated or locked
    logic force_ready;                          // Locked under a forced power gate
    logic assert_clkreq;                        // Clock request level
    logic force_gate;                           // Registered pwrgate_force
    logic unlock_domain;                        // One cycle strobe, leave the locked states

    modport main (
        output domain_locked, ism_wake, force_ready,
        input  force_gate, unlock_domain
    );

    modport pg (
        input  domain_locked, ism_wake, force_ready,
        output assert_clkreq, force_gate, unlock_domain
    );

endinterface : cdc_ctrl_if

// ==== verilog/cdc_wake_merge.sv ====
`timescale 1ns/1ps

module cdc_wake_merge (
    input  logic                           clock,            // Main clock
    input  logic                           reset,            // Sync reset, active high
    input  logic                           gclock_req_sync,  // Sync gclock request
    input  logic [cdc_cfg_pkg::AREQ-1:0]   gclock_req_async, // Glitch free async requests
    input  cdc_state_pkg::ism_state_t      ism_fabric,       // Fabric side ISM
    input  cdc_state_pkg::ism_state_t      ism_agent,        // Agent side ISM
    input  logic                           gclock_active,    // Gated clock running
    output logic [cdc_cfg_pkg::AREQ-1:0]   gclock_ack_async, // Per request ack
    output logic                           busy              // Any activity, registered
);
    import cdc_cfg_pkg::*;
    import cdc_state_pkg::*;

    logic any_req;                              // Raw OR of every activity source

    assign any_req = gclock_req_sync
                   | (|gclock_req_async)
                   | (ism_fabric != ISM_IDLE)   // Any non idle ISM keeps the clock
                   | (ism_agent != ISM_IDLE);

    always_ff @(posedge clock) begin
        if (reset) begin
            busy             <= 1'b0;
            gclock_ack_async <= '0;
        end else begin
            busy             <= any_req;        // One cycle after the inputs
            gclock_ack_async <= gclock_req_async & {AREQ{gclock_active}}; // Ack only with clock up
        end
    end

    // An ack bit needs its request on the cycle before
    a_ack_has_req : assert property (
        @(posedge clock) disable iff (reset)
        (gclock_ack_async & ~$past(gclock_req_async)) == '0
    ) else $error("async ack without request");

endmodule : cdc_wake_merge

// ==== verilog/cdc_holdoff_timer.sv ====
`timescale 1ns/1ps

module cdc_holdoff_timer (
    input  logic                                clock,   // Main clock
    input  logic                                reset,   // Sync reset, active high
    input  logic                                start,   // Restart the count
    input  logic                                clear,   // Abort, go idle
    input  logic [cdc_cfg_pkg::HOLDOFF_W-1:0]   holdoff, // log2 of the wait in cycles
    output logic                                done     // High once, 2^holdoff after start
);
    import cdc_cfg_pkg::*;

    logic [ITBITS-1:0] count;                   // Cycles since start
    logic [ITBITS-1:0] target;                  // 2^holdoff, caught at start
    logic              running;

    assign done = running && (count == target);

    always_ff @(posedge clock) begin
        if (reset) begin
            running <= 1'b0;
            count   <= '0;
        end else if (clear) begin
            running <= 1'b0;
        end else if (start) begin
            running <= 1'b1;
            count   <= ITBITS'(1);              // First cycle after the start strobe
        end else if (done) begin
            running <= 1'b0;                    // One shot, wait for the next start
        end else if (running) begin
            count   <= count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            target <= ITBITS'(1) << holdoff;    // Held so config changes do not move it
        end
    end

    // Done comes only from a start, either just now or while counting
    a_done_after_start : assert property (
        @(posedge clock) disable iff (reset)
        $rose(done) |-> ($past(start) || $past(running))
    ) else $error("holdoff done without start");

endmodule : cdc_holdoff_timer

// ==== verilog/cdc_main_fsm.sv ====
`timescale 1ns/1ps

module cdc_main_fsm (
    input  logic                              clock,                   // Main clock
    input  logic                              reset,                   // Sync reset, active high
    input  logic                              busy,                    // Merged activity
    input  logic                              clkack,                  // Clock request ack level
    input  logic                              cfg_clkgate_disabled,    // No idle gating
    input  logic                              cfg_clkreq_ctl_disabled, // Keep clkreq when gated
    input  logic [cdc_cfg_pkg::HOLDOFF_W-1:0] cfg_clkgate_holdoff,     // Idle to gate, log2
    input  logic [cdc_cfg_pkg::HOLDOFF_W-1:0] cfg_clkreq_off_holdoff,  // Gate to clkreq off, log2
    cdc_ctrl_if.main                          ctrl,                    // To the power gate side
    output logic                              gclock_enable_final,     // Clock gate enable
    output logic                              gclock_active,           // Gated clock running
    output logic                              ism_locked,              // Hold the ISMs
    output logic                              boundary_locked          // Block non IOSF access
);
    import cdc_state_pkg::*;

    cdc_state_t state;
    cdc_state_t next_state;
    logic       idle_start, idle_clear, idle_done;  // Idle holdoff timer
    logic       off_start, off_clear, off_done;     // clkreq off holdoff timer

    always_comb begin
        next_state = state;
        case (state)
            ACTIVE: begin
                if (ctrl.force_gate) begin
                    next_state = GATED;             // Force skips the idle holdoff
                end else if (!busy && !cfg_clkgate_disabled) begin
                    next_state = IDLE_HOLD;
                end
            end
            IDLE_HOLD: begin
                if (ctrl.force_gate) begin
                    next_state = GATED;
                end else if (busy || cfg_clkgate_disabled) begin
                    next_state = ACTIVE;
                end else if (idle_done) begin
                    next_state = GATED;
                end
            end
            GATED: begin
                if (busy && !ctrl.force_gate) begin
                    next_state = ACTIVE;            // clkreq never dropped, ungate at once
                end else if (ctrl.force_gate || (off_done && !cfg_clkreq_ctl_disabled)) begin
                    next_state = OFF_PENDING;
                end
            end
            OFF_PENDING: begin
                if (ctrl.unlock_domain) begin
                    next_state = WAKE_WAIT;
                end else if (!clkack) begin
                    next_state = LOCKED;            // Clock source confirmed off
                end
            end
            LOCKED: begin
                if (ctrl.unlock_domain) begin
                    next_state = WAKE_WAIT;
                end
            end
            WAKE_WAIT: begin
                if (clkack) begin
                    next_state = ACTIVE;
                end
            end
            default: next_state = ACTIVE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ACTIVE;
        end else begin
            state <= next_state;
        end
    end

    // Timer controls from the state transition
    assign idle_start = (state == ACTIVE) && (next_state == IDLE_HOLD);
    assign idle_clear = (state == IDLE_HOLD) && (next_state != IDLE_HOLD);
    assign off_start  = (state != GATED) && (next_state == GATED);
    assign off_clear  = (state == GATED) && (next_state != GATED);

    cdc_holdoff_timer u_idle_timer (
        .clock   (clock),
        .reset   (reset),
        .start   (idle_start),
        .clear   (idle_clear),
        .holdoff (cfg_clkgate_holdoff),
        .done    (idle_done)
    );

    cdc_holdoff_timer u_clkreq_off_timer (
        .clock   (clock),
        .reset   (reset),
        .start   (off_start),
        .clear   (off_clear),
        .holdoff (cfg_clkreq_off_holdoff),
        .done    (off_done)
    );

    assign gclock_active       = (state == ACTIVE) || (state == IDLE_HOLD);
    assign gclock_enable_final = gclock_active || ((state == WAKE_WAIT) && clkack); // Open early
    assign ism_locked          = !gclock_active;
    assign boundary_locked     = (state == GATED) || (state == OFF_PENDING) ||
                                 (state == LOCKED) || (state == WAKE_WAIT);

    // clkreq may start dropping from OFF_PENDING onward
    assign ctrl.domain_locked = (state == OFF_PENDING) || (state == LOCKED);
    assign ctrl.ism_wake      = busy && ((state == GATED) || ctrl.domain_locked);
    assign ctrl.force_ready   = ctrl.domain_locked && ctrl.force_gate;

    a_enable_unlocked : assert property (
        @(posedge clock) disable iff (reset) gclock_enable_final |-> !ctrl.domain_locked
    ) else $error("gate enabled while domain locked");

    a_boundary_in_ism : assert property (
        @(posedge clock) disable iff (reset) boundary_locked |-> ism_locked
    ) else $error("boundary locked without ISM lock");

endmodule : cdc_main_fsm

// ==== verilog/cdc_pg_ctrl.sv ====
`timescale 1ns/1ps

module cdc_pg_ctrl (
    input  logic     clock,             // Main clock
    input  logic     reset,             // Sync reset, active high
    input  logic     pwrgate_disabled,  // No idle power gating
    input  logic     pwrgate_force,     // Force gate and lock
    input  logic     pwrgate_pmc_wake,  // PMC wake
    input  logic     clkack,            // Clock request ack level
    cdc_ctrl_if.pg   ctrl,              // From the main controller
    output logic     clkreq,            // Clock request level
    output logic     pwrgate_ready      // Power gating allowed
);
    logic clkreq_q;
    logic clkreq_next;
    logic force_q;
    logic unlock_q;
    logic wake_evt;                     // Any reason to bring the clock back

    assign wake_evt = ctrl.ism_wake | pwrgate_pmc_wake;

    always_comb begin
        clkreq_next = clkreq_q;
        if (wake_evt && !ctrl.force_ready) begin
            clkreq_next = 1'b1;                         // Wake wins unless held by force
        end else if (ctrl.domain_locked && !unlock_q) begin
            clkreq_next = 1'b0;                         // Keep it up while unlock in flight
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            clkreq_q      <= 1'b1;                      // Clock requested out of reset
            force_q       <= 1'b0;
            unlock_q      <= 1'b0;
            pwrgate_ready <= 1'b0;
        end else begin
            clkreq_q      <= clkreq_next;
            force_q       <= pwrgate_force;
            // Single pulse, the FSM leaves the locked states on it
            unlock_q      <= wake_evt && ctrl.domain_locked && !ctrl.force_ready && !unlock_q;
            pwrgate_ready <= ctrl.domain_locked && !clkack && !clkreq_next &&
                             (!pwrgate_disabled || ctrl.force_ready);
        end
    end

    assign ctrl.assert_clkreq = clkreq_q;
    assign ctrl.force_gate    = force_q;
    assign ctrl.unlock_domain = unlock_q;
    assign clkreq             = ctrl.assert_clkreq;

    // Power gate only with the clock request dropped
    a_ready_no_clkreq : assert property (
        @(posedge clock) disable iff (reset) pwrgate_ready |-> !clkreq
    ) else $error("pwrgate_ready with clkreq high");

endmodule : cdc_pg_ctrl

// ==== verilog/cdc_top.sv ====
`timescale 1ns/1ps

module cdc_top (
    input  logic                              clock,                   // Main clock
    input  logic                              reset,                   // Sync reset, active high
    output logic                              clkreq,                  // Clock request level
    input  logic                              clkack,                  // Clock request ack level
    output logic                              gclock_enable_final,     // Clock gate enable
    input  logic                              gclock_req_sync,         // Sync gclock request
    input  logic [cdc_cfg_pkg::AREQ-1:0]      gclock_req_async,        // Async gclock requests
    output logic [cdc_cfg_pkg::AREQ-1:0]      gclock_ack_async,        // Async request acks
    output logic                              gclock_active,           // Gated clock running
    input  cdc_state_pkg::ism_state_t         ism_fabric,              // Fabric ISM
    input  cdc_state_pkg::ism_state_t         ism_agent,               // Agent ISM
    output logic                              ism_locked,              // ISM lock
    output logic                              boundary_locked,         // Boundary lock
    input  logic                              cfg_clkgate_disabled,    // No idle gating
    input  logic                              cfg_clkreq_ctl_disabled, // Keep clkreq when gated
    input  logic [cdc_cfg_pkg::HOLDOFF_W-1:0] cfg_clkgate_holdoff,     // Idle to gate, log2
    input  logic [cdc_cfg_pkg::HOLDOFF_W-1:0] cfg_clkreq_off_holdoff,  // Gate to clkreq off, log2
    input  logic                              pwrgate_disabled,        // No idle power gating
    input  logic                              pwrgate_force,           // Force power gate
    input  logic                              pwrgate_pmc_wake,        // PMC wake
    output logic                              pwrgate_ready            // Power gating allowed
);
    logic busy;                                 // Merged activity, registered

    cdc_ctrl_if u_ctrl_if ();

    cdc_wake_merge u_wake_merge (
        .clock            (clock),
        .reset            (reset),
        .gclock_req_sync  (gclock_req_sync),
        .gclock_req_async (gclock_req_async),
        .ism_fabric       (ism_fabric),
        .ism_agent        (ism_agent),
        .gclock_active    (gclock_active),
        .gclock_ack_async (gclock_ack_async),
        .busy             (busy)
    );

    cdc_main_fsm u_main_fsm (
        .clock                   (clock),
        .reset                   (reset),
        .busy                    (busy),
        .clkack                  (clkack),
        .cfg_clkgate_disabled    (cfg_clkgate_disabled),
        .cfg_clkreq_ctl_disabled (cfg_clkreq_ctl_disabled),
        .cfg_clkgate_holdoff     (cfg_clkgate_holdoff),
        .cfg_clkreq_off_holdoff  (cfg_clkreq_off_holdoff),
        .ctrl                    (u_ctrl_if.main),
        .gclock_enable_final     (gclock_enable_final),
        .gclock_active           (gclock_active),
        .ism_locked              (ism_locked),
        .boundary_locked         (boundary_locked)
    );

    cdc_pg_ctrl u_pg_ctrl (
        .clock            (clock),
        .reset            (reset),
        .pwrgate_disabled (pwrgate_disabled),
        .pwrgate_force    (pwrgate_force),
        .pwrgate_pmc_wake (pwrgate_pmc_wake),
        .clkack           (clkack),
        .ctrl             (u_ctrl_if.pg),
        .clkreq           (clkreq),
        .pwrgate_ready    (pwrgate_ready)
    );

endmodule : cdc_top

// ==== verification/cdc_tb.sv ====
`timescale 1ns/1ps

module cdc_tb;
    import cdc_cfg_pkg::*;
    import cdc_state_pkg::*;

    localparam int          CLK_PERIOD  = 40;
    localparam int          T_RESET     = 16;
    localparam logic [31:0] SEED        = 32'h36fe8a3c;
    localparam int          T_GATE      = 40;       // Idle gating with the request pulse
    localparam int          T_CLKREQ    = 100;      // Held gate, re-gate, clkreq off, ready
    localparam int          T_WAKE      = 30;
    localparam int          T_FORCE     = 50;
    localparam int          WATCHDOG_CYCLES = T_RESET + T_GATE + T_CLKREQ + T_WAKE + T_FORCE + 100;
    localparam logic [4:0]  FLAGS_RUN   = 5'b10010; // {active, ism, boundary, clkreq, ready}
    localparam logic [4:0]  FLAGS_GATED = 5'b01110;
    localparam logic [4:0]  FLAGS_OFF   = 5'b01100; // Locked, power gate not allowed
    localparam logic [4:0]  FLAGS_READY = 5'b01101;

    logic                 clock, reset, clkreq, clkack, gclock_enable_final;
    logic                 gclock_req_sync, gclock_active, ism_locked, boundary_locked;
    logic [AREQ-1:0]      gclock_req_async, gclock_ack_async;
    ism_state_t           ism_fabric, ism_agent;
    logic                 cfg_clkgate_disabled, cfg_clkreq_ctl_disabled;
    logic [HOLDOFF_W-1:0] cfg_clkgate_holdoff, cfg_clkreq_off_holdoff;
    logic                 pwrgate_disabled, pwrgate_force, pwrgate_pmc_wake, pwrgate_ready;
    logic [1:0]           ack_dly;                  // clkack model pipeline
    int                   hold_gate, hold_off;      // log2 holdoffs picked for the run

    cdc_top DUT (.*);

    always #(CLK_PERIOD / 2) clock = ~clock;

    // Clock source model, clkack follows clkreq three edges later
    always @(posedge clock) begin
        if (reset) begin
            ack_dly <= 2'b11;
            clkack  <= 1'b1;
        end else begin
            ack_dly <= {ack_dly[0], clkreq};
            clkack  <= ack_dly[1];
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout, controller did not finish");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic raise_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            raise_error($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_ack(input logic [AREQ-1:0] got, input logic [AREQ-1:0] exp);
        if (got !== exp) begin
            raise_error($sformatf("mismatch gclock_ack_async: got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_state_flags(input string where, input logic [4:0] exp);
        logic [4:0] got;
        got = {gclock_active, ism_locked, boundary_locked, clkreq, pwrgate_ready};
        if (got !== exp) begin
            raise_error($sformatf("mismatch state_flags at %s: got 0x%h expected 0x%h",
                                  where, got, exp));
        end
    endtask

    function automatic logic probe(input string name);
        if (name == "gclock_active") return gclock_active;
        else if (name == "clkreq") return clkreq;
        else if (name == "clkack") return clkack;
        else if (name == "pwrgate_ready") return pwrgate_ready;
        else return 1'bx;
    endfunction

    // Polls at the falling edge until the output reaches the level
    task automatic wait_for(input string name, input logic level, input int max_cycles);
        int cycles;
        cycles = 0;
        while (probe(name) !== level) begin
            if (cycles >= max_cycles) begin
                raise_error($sformatf("%s did not reach %0b within %0d cycles",
                                      name, level, max_cycles));
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    task automatic test_reset_values();
        check_state_flags("after reset", FLAGS_RUN);
        check_bit("gclock_enable_final", gclock_enable_final, 1'b1);
        check_ack(gclock_ack_async, '0);
    endtask

    task automatic test_idle_gating();
        int cycles;
        @(posedge clock) gclock_req_sync <= 1'b0;
        repeat (2) @(posedge clock);
        gclock_req_sync <= 1'b1;                  // Short request inside the holdoff
        @(posedge clock) gclock_req_sync <= 1'b0;
        repeat (4) begin
            @(negedge clock);
            check_state_flags("idle holdoff", FLAGS_RUN);
        end
        cycles = 4;
        while (gclock_active === 1'b1) begin
            check_bit("ism_locked", ism_locked, 1'b0);
            if (cycles > (1 << hold_gate) + 8) raise_error("gclock_active did not fall after idle");
            @(negedge clock);
            cycles++;
        end
        // busy falls again two edges into the count, the holdoff runs from there
        if (cycles < (1 << hold_gate) + 2) begin
            raise_error($sformatf("gclock_active fell %0d cycles after idle, holdoff is %0d cycles",
                                  cycles - 2, 1 << hold_gate));
        end
        check_state_flags("gating edge", FLAGS_GATED);  // Locks rise with the gate
        check_bit("gclock_enable_final", gclock_enable_final, 1'b0);
    endtask

    task automatic test_clkreq_off();
        repeat ((1 << hold_off) + 8) begin           // clkreq control disabled keeps the request
            @(negedge clock);
            check_state_flags("clkreq control disabled", FLAGS_GATED);
        end
        @(posedge clock) gclock_req_sync <= 1'b1;
        wait_for("gclock_active", 1'b1, 6);
        @(posedge clock);
        gclock_req_sync         <= 1'b0;
        cfg_clkreq_ctl_disabled <= 1'b0;
        @(negedge clock);
        wait_for("gclock_active", 1'b0, (1 << hold_gate) + 8);
        wait_for("clkreq", 1'b0, (1 << hold_off) + 8);
        check_bit("pwrgate_ready", pwrgate_ready, 1'b0);
        wait_for("clkack", 1'b0, 8);
        repeat (3) @(negedge clock);
        check_state_flags("locked, power gate disabled", FLAGS_OFF);
        @(posedge clock) pwrgate_disabled <= 1'b0;
        wait_for("pwrgate_ready", 1'b1, 4);
        check_state_flags("power gate ready", FLAGS_READY);
    endtask

    task automatic test_wake();
        int              kind;
        int              cycles;
        logic            prev_clkack;
        logic [AREQ-1:0] mask;
        mask = '0;
        kind = $urandom % (AREQ + 1);               // Async bit or non idle ISM
        @(posedge clock);
        if (kind < AREQ) begin
            mask[kind]       = 1'b1;
            gclock_req_async <= mask;
        end else begin
            ism_fabric <= ism_state_t'(1 + $urandom % 7);
        end
        @(negedge clock);
        wait_for("clkreq", 1'b1, 6);
        check_bit("pwrgate_ready", pwrgate_ready, 1'b0);
        check_ack(gclock_ack_async, '0);
        cycles      = 0;
        prev_clkack = clkack;
        while (gclock_active !== 1'b1) begin
            if (cycles > 12) raise_error("gclock_active did not return after the wake");
            prev_clkack = clkack;
            @(negedge clock);
            cycles++;
        end
        check_bit("clkack before ungate", prev_clkack, 1'b1);
        check_bit("gclock_enable_final", gclock_enable_final, 1'b1);
        @(negedge clock);
        check_ack(gclock_ack_async, mask);          // Ack one edge after the clock is back
        @(posedge clock);
        gclock_req_async <= '0;
        ism_fabric       <= ISM_IDLE;
        repeat (2) @(negedge clock);
        check_ack(gclock_ack_async, '0);
    endtask

    task automatic test_force();
        @(posedge clock) gclock_req_sync <= 1'b1;
        @(negedge clock);
        wait_for("gclock_active", 1'b1, 6);
        @(posedge clock);
        pwrgate_disabled <= 1'b1;
        pwrgate_force    <= 1'b1;                   // Gate despite the live request
        @(negedge clock);
        wait_for("gclock_active", 1'b0, 6);
        check_state_flags("forced gate", FLAGS_GATED);
        wait_for("pwrgate_ready", 1'b1, 12);
        repeat (8) begin
            check_state_flags("forced lock", FLAGS_READY);
            @(negedge clock);
        end
        @(posedge clock) pwrgate_force <= 1'b0;
        @(negedge clock);
        wait_for("gclock_active", 1'b1, 16);
        check_state_flags("force released", FLAGS_RUN);
        @(posedge clock) gclock_req_sync <= 1'b0;
        @(negedge clock);
    endtask

    initial begin
        void'($urandom(SEED));
        hold_gate               = 1 + $urandom % 4;
        hold_off                = 1 + $urandom % 4;
        clock                   = 1'b0;
        reset                   = 1'b1;
        clkack                  = 1'b1;
        ack_dly                 = 2'b11;
        gclock_req_sync         = 1'b1;             // Busy until the gating test
        gclock_req_async        = '0;
        ism_fabric              = ISM_IDLE;
        ism_agent               = ISM_IDLE;
        cfg_clkgate_disabled    = 1'b0;
        cfg_clkreq_ctl_disabled = 1'b1;
        cfg_clkgate_holdoff     = HOLDOFF_W'(hold_gate);
        cfg_clkreq_off_holdoff  = HOLDOFF_W'(hold_off);
        pwrgate_disabled        = 1'b1;
        pwrgate_force           = 1'b0;
        pwrgate_pmc_wake        = 1'b0;
        repeat (T_RESET) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        test_reset_values();
        test_idle_gating();
        test_clkreq_off();
        test_wake();
        test_force();
        $display("TEST PASS");
        $finish;
    end

endmodule : cdc_tb

// ==== src.f ====
verilog/cdc_cfg_pkg.sv
verilog/cdc_state_pkg.sv
verilog/cdc_ctrl_if.sv
verilog/cdc_wake_merge.sv
verilog/cdc_holdoff_timer.sv
verilog/cdc_main_fsm.sv
verilog/cdc_pg_ctrl.sv
verilog/cdc_top.sv
verification/cdc_tb.sv
